/* hdl/i2c_seq_params.svh */
`ifndef I2C_SEQ_PARAMS_SVH
`define I2C_SEQ_PARAMS_SVH

// datapath sizes
`define I2C_WORD_W          32      // one command word = one i2c transaction
`define I2C_FIFO_DEPTH      16
`define I2C_FIFO_AW         4       // depth is 2**aw, pointers wrap on their own
`define I2C_QDLY_W          8       // quarter-bit delay register width

// values loaded by reset_cmd
`define I2C_QDLY_DEFAULT    8'd100  // quarter bit = 101 mclk cycles
`define I2C_BYTES_DEFAULT   2'd3    // address byte plus three data bytes

// control word layout, single bits or field lsb
`define CTL_FLUSH_BIT       14      // empty fifo, stop engine
`define CTL_RUN_SET_BIT     13      // apply run value below
`define CTL_RUN_VAL_BIT     12
`define CTL_BYTES_SET_BIT   11      // apply byte count field
`define CTL_BYTES_LSB       9       // 2-bit field
`define CTL_QDLY_SET_BIT    8       // apply quarter delay field
`define CTL_QDLY_LSB        0       // 8-bit field

// data byte positions inside a command word
`define I2C_BYTES_W         2
`define I2C_SR_W            9       // data byte plus released ack bit

`endif

/* hdl/i2c_seq_pkg.sv */
package i2c_seq_pkg;

    // command port opcodes
    typedef enum logic [0:0] {
        OP_PUSH = 1'b0,     // queue cmd_data as an i2c write
        OP_CTRL = 1'b1      // cmd_data is a control word
    } cmd_op_t;

    // bit engine phases
    typedef enum logic [2:0] {
        PH_IDLE  = 3'd0,    // bus released, scl high
        PH_START = 3'd1,    // sda falls while scl high
        PH_DATA  = 3'd2,    // 8 data bits, msb first
        PH_ACKN  = 3'd3,    // slave ack slot, sda released
        PH_STOP  = 3'd4     // sda rises while scl high
    } phase_t;

    // ack is never sampled, the engine is write only

endpackage

/* hdl/cmd_port.sv */
`timescale 1ns/1ns
`include "i2c_seq_params.svh"

module cmd_port (
    input  logic                        mclk,
    input  logic                        reset_cmd,
    input  logic                        cmd_req,        // host request, held until ack
    input  i2c_seq_pkg::cmd_op_t        cmd_op,
    input  logic [`I2C_WORD_W-1:0]      cmd_data,
    input  logic                        full,           // fifo back-pressure
    output logic                        cmd_ack,
    output logic                        push,           // one cycle, with ack rise
    output logic [`I2C_WORD_W-1:0]      push_data,
    output logic                        flush,          // one cycle
    output logic                        stop_now,       // abort to the bit engine
    output logic                        run_en,
    output logic [`I2C_BYTES_W-1:0]     byte_count,
    output logic [`I2C_QDLY_W-1:0]      quarter_dly
);

    logic is_ctrl;      // current request carries a control word
    logic req_new;      // request seen, not yet acknowledged
    logic serve;        // request completes this cycle
    logic flush_cmd;    // control word asks for a flush

    assign is_ctrl   = (cmd_op == i2c_seq_pkg::OP_CTRL);
    assign req_new   = cmd_req && !cmd_ack;
    assign serve     = req_new && (is_ctrl || !full);  // pushes wait for a free slot
    assign flush_cmd = serve && is_ctrl && cmd_data[`CTL_FLUSH_BIT];

    // four-phase responder and control registers
    always_ff @(posedge mclk) begin
        if (reset_cmd) begin
            cmd_ack     <= 1'b0;
            push        <= 1'b0;
            flush       <= 1'b0;
            stop_now    <= 1'b0;
            run_en      <= 1'b0;
            byte_count  <= `I2C_BYTES_DEFAULT;
            quarter_dly <= `I2C_QDLY_DEFAULT;
        end else begin
            push     <= serve && !is_ctrl;
            flush    <= flush_cmd;
            stop_now <= flush_cmd;              // also kills a running transaction

            if (serve)
                cmd_ack <= 1'b1;
            else if (!cmd_req)
                cmd_ack <= 1'b0;                // host dropped req, close handshake

            // fields visible in the same cycle as the ack
            if (serve && is_ctrl) begin
                if (cmd_data[`CTL_FLUSH_BIT])
                    run_en <= 1'b0;             // flush wins over run
                else if (cmd_data[`CTL_RUN_SET_BIT])
                    run_en <= cmd_data[`CTL_RUN_VAL_BIT];
                if (cmd_data[`CTL_BYTES_SET_BIT])
                    byte_count <= cmd_data[`CTL_BYTES_LSB +: `I2C_BYTES_W];
                if (cmd_data[`CTL_QDLY_SET_BIT])
                    quarter_dly <= cmd_data[`CTL_QDLY_LSB +: `I2C_QDLY_W];
            end
        end
    end

    // word travels to the fifo together with push
    always_ff @(posedge mclk) begin
        if (serve)
            push_data <= cmd_data;
    end

    // ack only answers a request that was already up
    a_ack_after_req: assert property (
        @(posedge mclk) disable iff (reset_cmd)
        $rose(cmd_ack) |-> $past(cmd_req)
    );

    // fifo never overrun by this port
    a_no_push_full: assert property (
        @(posedge mclk) disable iff (reset_cmd)
        push |-> !full
    );

endmodule

/* hdl/cmd_fifo.sv */
`timescale 1ns/1ns
`include "i2c_seq_params.svh"

module cmd_fifo (
    input  logic                        mclk,
    input  logic                        reset_cmd,
    input  logic                        push,
    input  logic [`I2C_WORD_W-1:0]      push_data,
    input  logic                        pop,            // from bit engine, one cycle
    input  logic                        flush,          // drop everything queued
    output logic [`I2C_WORD_W-1:0]      head_data,
    output logic                        empty,
    output logic                        full
);

    logic [`I2C_WORD_W-1:0]  mem [0:`I2C_FIFO_DEPTH-1];
    logic [`I2C_FIFO_AW-1:0] wr_ptr;
    logic [`I2C_FIFO_AW-1:0] rd_ptr;
    logic [`I2C_FIFO_AW:0]   count;     // one extra bit to tell full from empty
    logic                    do_push;
    logic                    do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // pointers and occupancy
    always_ff @(posedge mclk) begin
        if (reset_cmd || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;                           // flush empties in one cycle
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;            // wraps at depth
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;            // both or neither
            endcase
        end
    end

    // word storage
    always_ff @(posedge mclk) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    assign head_data = mem[rd_ptr];                 // valid one cycle after push
    assign empty     = (count == '0);
    assign full      = (count == (`I2C_FIFO_AW+1)'(`I2C_FIFO_DEPTH));

    // engine must only take words that exist
    a_no_pop_empty: assert property (
        @(posedge mclk) disable iff (reset_cmd)
        pop |-> !empty
    );

endmodule

/* hdl/i2c_bit_engine.sv */
`timescale 1ns/1ns
`include "i2c_seq_params.svh"

module i2c_bit_engine (
    input  logic                        mclk,
    input  logic                        reset_cmd,
    input  logic                        run_en,
    input  logic [`I2C_BYTES_W-1:0]     byte_count,     // bytes after the address
    input  logic [`I2C_QDLY_W-1:0]      quarter_dly,    // quarter bit = quarter_dly+1 cycles
    input  logic                        stop_now,       // abort current transaction
    input  logic                        empty,
    input  logic [`I2C_WORD_W-1:0]      head_data,
    output logic                        pop,
    output logic                        busy_tx,
    output logic                        scl,
    output logic                        sda_out,
    output logic                        sda_en
);

    i2c_seq_pkg::phase_t             phase;
    logic [`I2C_QDLY_W-1:0]          dly_cnt;       // quarter-bit down counter
    logic [1:0]                      qcnt;          // quarter within a bit
    logic [2:0]                      bit_idx;       // data bit within a byte
    logic [`I2C_BYTES_W-1:0]         bytes_left;    // bytes still to follow
    logic [`I2C_SR_W-1:0]            sr;            // msb drives sda
    logic [`I2C_WORD_W-9:0]          word_r;        // bytes not yet loaded into sr
    logic                            start_tx;
    logic                            tick;          // last cycle of a quarter
    logic                            bit_end;       // last cycle of a bit
    logic                            scl_c;
    logic                            sda_c;
    logic                            en_c;

    assign start_tx = (phase == i2c_seq_pkg::PH_IDLE) && run_en && !empty && !stop_now;
    assign pop      = start_tx;                     // head latched on the same edge
    assign tick     = (dly_cnt == '0);
    assign bit_end  = tick && (qcnt == 2'd3);
    assign busy_tx  = (phase != i2c_seq_pkg::PH_IDLE);

    // phase sequencer
    always_ff @(posedge mclk) begin
        if (reset_cmd || stop_now) begin
            phase      <= i2c_seq_pkg::PH_IDLE;
            dly_cnt    <= '0;
            qcnt       <= 2'd0;
            bit_idx    <= 3'd0;
            bytes_left <= '0;
        end else if (start_tx) begin
            phase      <= i2c_seq_pkg::PH_START;
            dly_cnt    <= quarter_dly;
            qcnt       <= 2'd0;
            bytes_left <= byte_count;               // sampled once per transaction
        end else if (busy_tx) begin
            if (tick) begin
                dly_cnt <= quarter_dly;
                qcnt    <= qcnt + 1'b1;             // wraps 3 -> 0 at bit end
            end else begin
                dly_cnt <= dly_cnt - 1'b1;
            end
            if (bit_end) begin
                case (phase)
                    i2c_seq_pkg::PH_START: begin
                        phase   <= i2c_seq_pkg::PH_DATA;
                        bit_idx <= 3'd0;
                    end
                    i2c_seq_pkg::PH_DATA: begin
                        if (bit_idx == 3'd7)
                            phase <= i2c_seq_pkg::PH_ACKN;
                        bit_idx <= bit_idx + 1'b1;
                    end
                    i2c_seq_pkg::PH_ACKN: begin
                        if (bytes_left != '0) begin
                            phase      <= i2c_seq_pkg::PH_DATA;  // next byte
                            bit_idx    <= 3'd0;
                            bytes_left <= bytes_left - 1'b1;
                        end else begin
                            phase <= i2c_seq_pkg::PH_STOP;
                        end
                    end
                    default: phase <= i2c_seq_pkg::PH_IDLE;      // end of stop
                endcase
            end
        end
    end

    // byte shifter
    always_ff @(posedge mclk) begin
        if (start_tx) begin
            sr     <= {head_data[`I2C_WORD_W-1 -: 8], 1'b1};     // slave address first
            word_r <= head_data[`I2C_WORD_W-9:0];
        end else if (bit_end && phase == i2c_seq_pkg::PH_DATA) begin
            sr <= {sr[`I2C_SR_W-2:0], 1'b1};                     // trailing 1 = ack release
        end else if (bit_end && phase == i2c_seq_pkg::PH_ACKN) begin
            sr     <= {word_r[`I2C_WORD_W-9 -: 8], 1'b1};
            word_r <= {word_r[`I2C_WORD_W-17:0], 8'h00};
        end
    end

    // line levels per quarter
    always_comb begin
        scl_c = 1'b1;
        sda_c = 1'b1;
        en_c  = 1'b0;
        case (phase)
            i2c_seq_pkg::PH_START: begin
                scl_c = (qcnt != 2'd3);             // high, high, high, low
                sda_c = (qcnt == 2'd0);             // falls in q1 under high scl
                en_c  = 1'b1;
            end
            i2c_seq_pkg::PH_DATA: begin
                scl_c = qcnt[1] ^ qcnt[0];          // high in q1 and q2
                sda_c = sr[`I2C_SR_W-1];            // steady for the whole bit
                en_c  = 1'b1;
            end
            i2c_seq_pkg::PH_ACKN: begin
                scl_c = qcnt[1] ^ qcnt[0];          // slave owns sda here
            end
            i2c_seq_pkg::PH_STOP: begin
                scl_c = (qcnt != 2'd0);
                sda_c = qcnt[1];                    // rises in q2 under high scl
                en_c  = 1'b1;
            end
            default: ;                              // idle, bus released
        endcase
    end

    // registered pins, same one-cycle lag on all three
    always_ff @(posedge mclk) begin
        if (reset_cmd) begin
            scl     <= 1'b1;
            sda_out <= 1'b1;
            sda_en  <= 1'b0;
        end else begin
            scl     <= scl_c;
            sda_out <= sda_c;
            sda_en  <= en_c;
        end
    end

    // ack slot leaves sda undriven once it reaches the pin
    a_ackn_released: assert property (
        @(posedge mclk) disable iff (reset_cmd)
        (phase == i2c_seq_pkg::PH_ACKN) |=> !sda_en
    );

    // every pop opens a transaction on the next cycle
    a_pop_starts: assert property (
        @(posedge mclk) disable iff (reset_cmd)
        pop |-> !empty ##1 (phase == i2c_seq_pkg::PH_START)
    );

endmodule

/* hdl/i2c_sequencer.sv */
`timescale 1ns/1ns
`include "i2c_seq_params.svh"

module i2c_sequencer (
    input  logic                        mclk,
    input  logic                        reset_cmd,
    input  logic                        cmd_req,
    input  i2c_seq_pkg::cmd_op_t        cmd_op,
    input  logic [`I2C_WORD_W-1:0]      cmd_data,
    output logic                        cmd_ack,
    output logic                        busy,
    output logic                        scl,
    output logic                        sda_out,
    output logic                        sda_en      // line low when high and sda_out is 0
);

    logic                        push;
    logic [`I2C_WORD_W-1:0]      push_data;
    logic                        flush;
    logic                        stop_now;
    logic                        full;
    logic                        empty;
    logic                        pop;
    logic [`I2C_WORD_W-1:0]      head_data;
    logic                        run_en;
    logic [`I2C_BYTES_W-1:0]     byte_count;
    logic [`I2C_QDLY_W-1:0]      quarter_dly;
    logic                        busy_tx;

    cmd_port u_cmd_port (
        .mclk(mclk), .reset_cmd(reset_cmd),
        .cmd_req(cmd_req), .cmd_op(cmd_op), .cmd_data(cmd_data), .full(full),
        .cmd_ack(cmd_ack), .push(push), .push_data(push_data),
        .flush(flush), .stop_now(stop_now),
        .run_en(run_en), .byte_count(byte_count), .quarter_dly(quarter_dly)
    );

    cmd_fifo u_cmd_fifo (
        .mclk(mclk), .reset_cmd(reset_cmd),
        .push(push), .push_data(push_data), .pop(pop), .flush(flush),
        .head_data(head_data), .empty(empty), .full(full)
    );

    i2c_bit_engine u_bit_engine (
        .mclk(mclk), .reset_cmd(reset_cmd),
        .run_en(run_en), .byte_count(byte_count), .quarter_dly(quarter_dly),
        .stop_now(stop_now), .empty(empty), .head_data(head_data),
        .pop(pop), .busy_tx(busy_tx),
        .scl(scl), .sda_out(sda_out), .sda_en(sda_en)
    );

    // running transaction, or words waiting to go out (also while stopped)
    assign busy = busy_tx || !empty;

endmodule

/* verification/i2c_bus_monitor.sv */
`timescale 1ns/1ns

module i2c_bus_monitor (
    input  logic        mclk,
    input  logic        reset_cmd,
    input  logic        scl,
    input  logic        sda_out,
    input  logic        sda_en,
    input  logic [7:0]  quarter_dly,    // setting in use, gives the scl high time
    output logic        start_seen,     // start condition in this cycle
    output logic        frame_done,     // one cycle, after each stop
    output logic [2:0]  frame_len,      // bytes in the finished transaction
    output logic [31:0] frame_bytes,    // last received byte in the low byte
    output int          bus_errors
);

    logic        sda_line;      // open drain line with pull-up
    logic        scl_q;
    logic        sda_q;
    logic        in_frame;
    logic [3:0]  bit_cnt;       // 0..7 data bits, 8 is the ack slot
    logic [6:0]  shift;
    logic [2:0]  nbytes;
    logic [31:0] bytes_acc;
    logic        cond_seen;     // start or stop inside the current scl high
    logic        stop_ev;
    logic        rise_ev;
    logic        fall_ev;
    int          high_cnt;
    int          exp_high;
    int          err_cnt = 0;

    assign sda_line   = !(sda_en && !sda_out);
    assign start_seen = scl_q && scl && sda_q && !sda_line;    // sda falls under high scl
    assign stop_ev    = scl_q && scl && !sda_q && sda_line;    // sda rises under high scl
    assign rise_ev    = !scl_q && scl;
    assign fall_ev    = scl_q && !scl;
    assign exp_high   = 2 * (int'(quarter_dly) + 1);           // scl high in q1 and q2
    assign bus_errors = err_cnt;

    always_ff @(posedge mclk) begin
        if (reset_cmd) begin
            scl_q <= 1'b1;
            sda_q <= 1'b1;
            in_frame <= 1'b0;
            bit_cnt <= 4'd0;
            shift <= 7'd0;
            nbytes <= 3'd0;
            bytes_acc <= 32'd0;
            frame_done <= 1'b0;
            frame_len <= 3'd0;
            frame_bytes <= 32'd0;
            high_cnt <= 0;
            cond_seen <= 1'b1;                  // idle high since reset is no bit
        end else begin
            scl_q <= scl;
            sda_q <= sda_line;
            frame_done <= 1'b0;
            if (start_seen) begin
                in_frame <= 1'b1;
                bit_cnt <= 4'd0;
                nbytes <= 3'd0;
                bytes_acc <= 32'd0;
            end else if (stop_ev) begin
                in_frame <= 1'b0;
                frame_done <= 1'b1;
                frame_len <= nbytes;
                frame_bytes <= bytes_acc;
            end else if (rise_ev && in_frame) begin
                if (bit_cnt == 4'd8) begin
                    bit_cnt <= 4'd0;            // ack slot, released and ignored
                end else begin
                    shift <= {shift[5:0], sda_line};
                    bit_cnt <= bit_cnt + 4'd1;
                    if (bit_cnt == 4'd7) begin
                        bytes_acc <= {bytes_acc[23:0], shift, sda_line};
                        nbytes <= nbytes + 3'd1;
                    end
                end
            end
            // length of each scl high
            if (rise_ev)
                high_cnt <= 1;
            else if (scl)
                high_cnt <= high_cnt + 1;
            if (rise_ev)
                cond_seen <= 1'b0;
            else if (start_seen || stop_ev)
                cond_seen <= 1'b1;
        end
    end

    // bit highs must last exactly two quarters
    a_scl_high: assert property (@(posedge mclk) disable iff (reset_cmd)
        (fall_ev && !cond_seen) |-> (high_cnt == exp_high))
    else begin
        $display("FAIL bus_timing scl high time expected %0d actual %0d",
                 $sampled(exp_high), $sampled(high_cnt));
        err_cnt = err_cnt + 1;
    end

    a_start_framing: assert property (@(posedge mclk) disable iff (reset_cmd)
        start_seen |-> !in_frame)
    else begin
        $display("sda fell under high scl in the middle of a transaction");
        err_cnt = err_cnt + 1;
    end

    // stop only after a whole byte and its ack slot
    // the scl rise of the stop itself was counted as bit 0
    a_stop_framing: assert property (@(posedge mclk) disable iff (reset_cmd)
        stop_ev |-> (in_frame && bit_cnt == 4'd1 && nbytes != 3'd0))
    else begin
        $display("sda rose under high scl away from a byte boundary");
        err_cnt = err_cnt + 1;
    end

endmodule

/* verification/i2c_seq_tb.sv */
`timescale 1ns/1ns
`include "i2c_seq_params.svh"

module i2c_seq_tb;

    localparam logic [31:0] SEED = 32'hfe12;
    localparam int QDLY_TEST   = 3;
    localparam int TX_WORST    = (4 + 36 * 4 + 4) * (QDLY_TEST + 1);  // address plus 3 bytes
    localparam int N_WORDS     = 36;                                  // all pushes, flushed too
    localparam int CYCLE_LIMIT = N_WORDS * TX_WORST + 2000;

    logic                 mclk = 1'b0;
    logic                 reset_cmd;
    logic                 cmd_req;
    i2c_seq_pkg::cmd_op_t cmd_op;
    logic [31:0]          cmd_data;
    logic                 cmd_ack;
    logic                 busy;
    logic                 scl;
    logic                 sda_out;
    logic                 sda_en;
    logic                 start_seen;
    logic                 frame_done;
    logic [2:0]           frame_len;
    logic [31:0]          frame_bytes;
    int                   bus_errors;
    logic [31:0]          exp_q[$];     // words still due on the bus, push order
    logic [31:0]          rng_state;
    logic [1:0]           bc_set;       // byte count the DUT holds
    logic [7:0]           qdly_set;
    logic                 run_flag;
    logic                 hold_chk;     // busy must stay high
    logic                 idle_chk;     // busy must stay low
    logic                 stall_chk;    // pending push must not be acked
    string                test_name;
    int                   hs_errors = 0;
    int                   seq_errors = 0;
    int                   cycles = 0;

    always #20 mclk = ~mclk;

    i2c_sequencer UUT (
        .mclk(mclk), .reset_cmd(reset_cmd),
        .cmd_req(cmd_req), .cmd_op(cmd_op), .cmd_data(cmd_data),
        .cmd_ack(cmd_ack), .busy(busy), .scl(scl), .sda_out(sda_out), .sda_en(sda_en)
    );

    i2c_bus_monitor u_bus_monitor (
        .mclk(mclk), .reset_cmd(reset_cmd), .scl(scl), .sda_out(sda_out), .sda_en(sda_en),
        .quarter_dly(qdly_set), .start_seen(start_seen), .frame_done(frame_done),
        .frame_len(frame_len), .frame_bytes(frame_bytes), .bus_errors(bus_errors)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // one four-phase handshake, returns once ack has dropped
    task automatic send_cmd(input i2c_seq_pkg::cmd_op_t op, input logic [31:0] data);
        @(negedge mclk);
        cmd_op = op;
        cmd_data = data;
        cmd_req = 1'b1;
        while (!cmd_ack) @(negedge mclk);
        cmd_req = 1'b0;
        while (cmd_ack) @(negedge mclk);
    endtask

    task automatic push_word(input logic keep);     // keep: word is due on the bus
        rng_state = xorshift(rng_state);
        send_cmd(i2c_seq_pkg::OP_PUSH, rng_state);
        if (keep)
            exp_q.push_back(rng_state);
    endtask

    task automatic set_run(input logic v);
        logic [31:0] ctl;
        ctl = 32'd0;
        ctl[`CTL_RUN_SET_BIT] = 1'b1;
        ctl[`CTL_RUN_VAL_BIT] = v;
        send_cmd(i2c_seq_pkg::OP_CTRL, ctl);
        run_flag = v;
    endtask

    task automatic set_bytes(input logic [1:0] bc);
        logic [31:0] ctl;
        ctl = 32'd0;
        ctl[`CTL_BYTES_SET_BIT] = 1'b1;
        ctl[`CTL_BYTES_LSB +: 2] = bc;
        send_cmd(i2c_seq_pkg::OP_CTRL, ctl);
        bc_set = bc;
    endtask

    task automatic set_qdly(input logic [7:0] qd);
        logic [31:0] ctl;
        ctl = 32'd0;
        ctl[`CTL_QDLY_SET_BIT] = 1'b1;
        ctl[`CTL_QDLY_LSB +: 8] = qd;
        send_cmd(i2c_seq_pkg::OP_CTRL, ctl);
        qdly_set = qd;
    endtask

    task automatic flush_fifo;
        logic [31:0] ctl;
        ctl = 32'd0;
        ctl[`CTL_FLUSH_BIT] = 1'b1;
        send_cmd(i2c_seq_pkg::OP_CTRL, ctl);
        run_flag = 1'b0;                            // flush also stops the engine
    endtask

    task automatic wait_idle;
        do @(negedge mclk); while (busy);
    endtask

    // top 1+byte_count bytes of the oldest word, msb first
    task automatic check_frame;
        logic [31:0] word;
        logic [31:0] exp_b;
        int          nexp;
        if (exp_q.size() == 0) begin
            $display("transaction on the bus with no word left to expect (%s)", test_name);
            seq_errors = seq_errors + 1;
        end else begin
            word = exp_q.pop_front();
            nexp = 1 + int'(bc_set);
            exp_b = word >> (8 * (3 - int'(bc_set)));
            assert (int'(frame_len) == nexp) else begin
                $display("FAIL %s byte count expected %0d actual %0d", test_name, nexp,
                         frame_len);
                seq_errors = seq_errors + 1;
            end
            assert (frame_bytes == exp_b) else begin
                $display("FAIL %s bytes expected %h actual %h", test_name, exp_b, frame_bytes);
                seq_errors = seq_errors + 1;
            end
        end
    endtask

    always @(negedge mclk) begin
        if (frame_done)
            check_frame();
    end

    a_ack_needs_req: assert property (@(posedge mclk) disable iff (reset_cmd)
        $rose(cmd_ack) |-> $past(cmd_req))
    else begin
        $display("cmd_ack rose without a pending request");
        hs_errors = hs_errors + 1;
    end

    a_ack_held: assert property (@(posedge mclk) disable iff (reset_cmd)
        $fell(cmd_ack) |-> $past(!cmd_req))
    else begin
        $display("cmd_ack dropped while cmd_req was still high");
        hs_errors = hs_errors + 1;
    end

    a_ack_release: assert property (@(posedge mclk) disable iff (reset_cmd)
        (cmd_ack && !cmd_req) |=> !cmd_ack)
    else begin
        $display("cmd_ack stayed high after cmd_req went low");
        hs_errors = hs_errors + 1;
    end

    a_ack_clear: assert property (@(posedge mclk) disable iff (reset_cmd)
        $rose(cmd_req) |-> !cmd_ack)
    else begin
        $display("new request raised before the previous ack dropped");
        hs_errors = hs_errors + 1;
    end

    a_stalled: assert property (@(posedge mclk) disable iff (reset_cmd)
        stall_chk |-> !cmd_ack)
    else begin
        $display("push acknowledged while the FIFO was full");
        hs_errors = hs_errors + 1;
    end

    a_no_start: assert property (@(posedge mclk) disable iff (reset_cmd)
        start_seen |-> run_flag)
    else begin
        $display("start condition while the engine was stopped (%s)", test_name);
        seq_errors = seq_errors + 1;
    end

    a_busy_held: assert property (@(posedge mclk) disable iff (reset_cmd)
        hold_chk |-> busy)
    else begin
        $display("FAIL %s busy expected 1 actual %0d", test_name, $sampled(busy));
        seq_errors = seq_errors + 1;
    end

    a_busy_low: assert property (@(posedge mclk) disable iff (reset_cmd)
        idle_chk |-> !busy)
    else begin
        $display("FAIL %s busy expected 0 actual %0d", test_name, $sampled(busy));
        seq_errors = seq_errors + 1;
    end

    always @(posedge mclk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] held_word;
        reset_cmd = 1'b1;
        cmd_req = 1'b0;
        cmd_op = i2c_seq_pkg::OP_PUSH;
        cmd_data = 32'd0;
        rng_state = SEED;
        bc_set = `I2C_BYTES_DEFAULT;
        qdly_set = `I2C_QDLY_DEFAULT;
        run_flag = 1'b0;
        hold_chk = 1'b0;
        idle_chk = 1'b0;
        stall_chk = 1'b0;
        test_name = "reset";
        repeat (8) @(negedge mclk);
        reset_cmd = 1'b0;
        set_qdly(8'(QDLY_TEST));                    // short quarters for the whole run

        test_name = "order_bc0";
        set_bytes(2'd0);
        set_run(1'b1);
        repeat (4) push_word(1'b1);
        wait_idle();
        test_name = "order_bc1";
        set_bytes(2'd1);
        repeat (4) push_word(1'b1);
        wait_idle();
        test_name = "order_bc3";
        set_bytes(2'd3);
        repeat (4) push_word(1'b1);
        wait_idle();

        // queued words wait for run
        test_name = "run_control";
        set_run(1'b0);
        repeat (3) push_word(1'b1);
        hold_chk = 1'b1;
        repeat (200) @(negedge mclk);
        hold_chk = 1'b0;
        set_run(1'b1);
        wait_idle();

        test_name = "back_pressure";
        set_run(1'b0);
        repeat (16) push_word(1'b1);                // fifo now full
        rng_state = xorshift(rng_state);
        held_word = rng_state;
        @(negedge mclk);
        cmd_op = i2c_seq_pkg::OP_PUSH;
        cmd_data = held_word;
        cmd_req = 1'b1;
        stall_chk = 1'b1;
        repeat (100) @(negedge mclk);
        stall_chk = 1'b0;
        cmd_req = 1'b0;                             // host gives up, retries after run
        set_run(1'b1);
        send_cmd(i2c_seq_pkg::OP_PUSH, held_word);
        exp_q.push_back(held_word);
        wait_idle();

        // flushed words never reach the bus
        test_name = "flush";
        set_run(1'b0);
        repeat (4) push_word(1'b0);
        hold_chk = 1'b1;
        repeat (20) @(negedge mclk);
        hold_chk = 1'b0;
        flush_fifo();
        idle_chk = 1'b1;
        repeat (300) @(negedge mclk);
        idle_chk = 1'b0;
        set_run(1'b1);                              // any frame now has no expected word
        repeat (300) @(negedge mclk);

        assert (exp_q.size() == 0) else begin
            $display("%0d queued words never appeared on the bus", exp_q.size());
            seq_errors = seq_errors + 1;
        end
        $display("error counts: handshake %0d, sequence %0d, bus %0d",
                 hs_errors, seq_errors, bus_errors);
        if (hs_errors + seq_errors + bus_errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

/* sim.f */
+incdir+hdl
hdl/i2c_seq_pkg.sv
hdl/cmd_port.sv
hdl/cmd_fifo.sv
hdl/i2c_bit_engine.sv
hdl/i2c_sequencer.sv
verification/i2c_bus_monitor.sv
verification/i2c_seq_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module i2c_seq_tb -f sim.f
	./obj_dir/Vi2c_seq_tb > sim.log 2>&1
	@cat sim.log
	@if grep -q "Checks failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
